// File: design/calc_pkg.sv
`default_nettype none

package calc_pkg;

  // Datapath and register file
  localparam int calc_data_width_lp     = 32;
  localparam int calc_reg_addr_width_lp = 5;
  localparam int calc_shamt_width_lp    = $clog2(calc_data_width_lp);

  // Completion pipe depth, writeback taken from the last stage
  localparam int calc_comp_els_lp = 5;

  // Every stage input plus the writeback stage output
  localparam int calc_fwd_els_lp  = calc_comp_els_lp + 1;

  // Stage input that receives each pipe result
  localparam int calc_int_stage_lp = 0;
  localparam int calc_aux_stage_lp = 1;
  localparam int calc_mul_stage_lp = 3;

  typedef enum logic [3:0]
  {
    // Integer pipe
    e_op_add  = 4'h0,
    e_op_sub  = 4'h1,
    e_op_and  = 4'h2,
    e_op_or   = 4'h3,
    e_op_xor  = 4'h4,
    e_op_sll  = 4'h5,
    e_op_srl  = 4'h6,
    e_op_slt  = 4'h7,

    // Auxiliary pipe
    e_op_min  = 4'h8,
    e_op_max  = 4'h9,
    e_op_minu = 4'ha,
    e_op_maxu = 4'hb,

    // Multiply pipe, low half of the product
    e_op_mul  = 4'hc
  } calc_op_e;

endpackage

`default_nettype wire

// File: design/calc_bypass.sv
`timescale 1ns/1ps
`default_nettype none

module calc_bypass
  (input  logic [calc_pkg::calc_reg_addr_width_lp-1:0] rs1_addr_i
  , input logic [calc_pkg::calc_reg_addr_width_lp-1:0] rs2_addr_i
  , input logic [calc_pkg::calc_data_width_lp-1:0]     rs1_data_i
  , input logic [calc_pkg::calc_data_width_lp-1:0]     rs2_data_i

  , input logic [calc_pkg::calc_fwd_els_lp-1:0]        fwd_v_i
  , input logic [calc_pkg::calc_fwd_els_lp-1:0][calc_pkg::calc_reg_addr_width_lp-1:0] fwd_addr_i
  , input logic [calc_pkg::calc_fwd_els_lp-1:0][calc_pkg::calc_data_width_lp-1:0]     fwd_data_i

  , output logic [calc_pkg::calc_data_width_lp-1:0]    rs1_o
  , output logic [calc_pkg::calc_data_width_lp-1:0]    rs2_o
  );

  // Entry 0 is the youngest, so scan oldest to youngest and let later hits win
  function automatic logic [calc_pkg::calc_data_width_lp-1:0] pick
    (input logic [calc_pkg::calc_reg_addr_width_lp-1:0] addr
    , input logic [calc_pkg::calc_data_width_lp-1:0] rf_data
    , input logic [calc_pkg::calc_fwd_els_lp-1:0] v
    , input logic [calc_pkg::calc_fwd_els_lp-1:0][calc_pkg::calc_reg_addr_width_lp-1:0] fwd_addr
    , input logic [calc_pkg::calc_fwd_els_lp-1:0][calc_pkg::calc_data_width_lp-1:0] fwd_data
    );
    logic [calc_pkg::calc_data_width_lp-1:0] sel;
    sel = rf_data;
    for (int i = calc_pkg::calc_fwd_els_lp-1; i >= 0; i--)
    begin
      if (v[i] && (fwd_addr[i] == addr))
      begin
        sel = fwd_data[i];
      end
    end
    // x0 is hardwired
    return (addr == '0) ? '0 : sel;
  endfunction

  assign rs1_o = pick(rs1_addr_i, rs1_data_i, fwd_v_i, fwd_addr_i, fwd_data_i);
  assign rs2_o = pick(rs2_addr_i, rs2_data_i, fwd_v_i, fwd_addr_i, fwd_data_i);

endmodule

`default_nettype wire

// File: design/calc_issue.sv
`timescale 1ns/1ps
`default_nettype none

module calc_issue
  (input  logic                                          clk_i
  , input logic                                          rst_n_i

  , input logic                                          dispatch_v_i
  , input logic                                          poison_i
  , input calc_pkg::calc_op_e                            op_i
  , input logic [calc_pkg::calc_reg_addr_width_lp-1:0]   rd_addr_i
  , input logic [calc_pkg::calc_reg_addr_width_lp-1:0]   rs1_addr_i
  , input logic [calc_pkg::calc_reg_addr_width_lp-1:0]   rs2_addr_i
  , input logic [calc_pkg::calc_data_width_lp-1:0]       rs1_data_i
  , input logic [calc_pkg::calc_data_width_lp-1:0]       rs2_data_i

  , input logic [calc_pkg::calc_fwd_els_lp-1:0]          fwd_v_i
  , input logic [calc_pkg::calc_fwd_els_lp-1:0][calc_pkg::calc_reg_addr_width_lp-1:0] fwd_addr_i
  , input logic [calc_pkg::calc_fwd_els_lp-1:0][calc_pkg::calc_data_width_lp-1:0]     fwd_data_i

  , output logic                                         res_v_o
  , output logic                                         res_kill_o
  , output calc_pkg::calc_op_e                           res_op_o
  , output logic [calc_pkg::calc_reg_addr_width_lp-1:0]  res_rd_addr_o
  , output logic [calc_pkg::calc_data_width_lp-1:0]      res_rs1_o
  , output logic [calc_pkg::calc_data_width_lp-1:0]      res_rs2_o
  );

  logic [calc_pkg::calc_data_width_lp-1:0] bypass_rs1, bypass_rs2;

  calc_bypass bypass
    (.rs1_addr_i(rs1_addr_i)
    ,.rs2_addr_i(rs2_addr_i)
    ,.rs1_data_i(rs1_data_i)
    ,.rs2_data_i(rs2_data_i)
    ,.fwd_v_i(fwd_v_i)
    ,.fwd_addr_i(fwd_addr_i)
    ,.fwd_data_i(fwd_data_i)
    ,.rs1_o(bypass_rs1)
    ,.rs2_o(bypass_rs2)
    );

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      res_v_o    <= 1'b0;
      res_kill_o <= 1'b0;
    end
    else
    begin
      res_v_o    <= dispatch_v_i;
      res_kill_o <= poison_i;
    end
  end

  // Reservation payload, corrected operands
  always_ff @(posedge clk_i)
  begin
    res_op_o      <= op_i;
    res_rd_addr_o <= rd_addr_i;
    res_rs1_o     <= bypass_rs1;
    res_rs2_o     <= bypass_rs2;
  end

endmodule

`default_nettype wire

// File: design/calc_pipe_int.sv
`timescale 1ns/1ps
`default_nettype none

module calc_pipe_int
  (input  logic                                     res_v_i
  , input calc_pkg::calc_op_e                       res_op_i
  , input logic [calc_pkg::calc_data_width_lp-1:0]  res_rs1_i
  , input logic [calc_pkg::calc_data_width_lp-1:0]  res_rs2_i

  , output logic                                    v_o
  , output logic [calc_pkg::calc_data_width_lp-1:0] data_o
  );

  logic                                      is_int;
  logic                                      lt;
  logic [calc_pkg::calc_shamt_width_lp-1:0]  shamt;

  assign lt    = $signed(res_rs1_i) < $signed(res_rs2_i);
  assign shamt = res_rs2_i[calc_pkg::calc_shamt_width_lp-1:0];

  always_comb
  begin
    is_int = 1'b1;
    data_o = '0;
    case (res_op_i)
      calc_pkg::e_op_add: data_o = res_rs1_i + res_rs2_i;
      calc_pkg::e_op_sub: data_o = res_rs1_i - res_rs2_i;
      calc_pkg::e_op_and: data_o = res_rs1_i & res_rs2_i;
      calc_pkg::e_op_or:  data_o = res_rs1_i | res_rs2_i;
      calc_pkg::e_op_xor: data_o = res_rs1_i ^ res_rs2_i;
      calc_pkg::e_op_sll: data_o = res_rs1_i << shamt;
      calc_pkg::e_op_srl: data_o = res_rs1_i >> shamt;
      calc_pkg::e_op_slt:
      begin
        data_o = {{(calc_pkg::calc_data_width_lp-1){1'b0}}, lt};
      end
      // Not an integer op, another pipe owns it
      default:
      begin
        is_int = 1'b0;
      end
    endcase
  end

  assign v_o = res_v_i & is_int;

endmodule

`default_nettype wire

// File: design/calc_pipe_aux.sv
`timescale 1ns/1ps
`default_nettype none

module calc_pipe_aux
  (input  logic                                     clk_i
  , input logic                                     rst_n_i

  , input logic                                     res_v_i
  , input calc_pkg::calc_op_e                       res_op_i
  , input logic [calc_pkg::calc_data_width_lp-1:0]  res_rs1_i
  , input logic [calc_pkg::calc_data_width_lp-1:0]  res_rs2_i

  , output logic                                    v_o
  , output logic [calc_pkg::calc_data_width_lp-1:0] data_o
  );

  logic                                    is_aux;
  logic                                    lt_s, lt_u;
  logic [calc_pkg::calc_data_width_lp-1:0] result;

  assign lt_s = $signed(res_rs1_i) < $signed(res_rs2_i);
  assign lt_u = res_rs1_i < res_rs2_i;

  always_comb
  begin
    is_aux = 1'b1;
    result = '0;
    case (res_op_i)
      calc_pkg::e_op_min:  result = lt_s ? res_rs1_i : res_rs2_i;
      calc_pkg::e_op_max:  result = lt_s ? res_rs2_i : res_rs1_i;
      calc_pkg::e_op_minu: result = lt_u ? res_rs1_i : res_rs2_i;
      calc_pkg::e_op_maxu: result = lt_u ? res_rs2_i : res_rs1_i;
      default:             is_aux = 1'b0;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
      v_o <= 1'b0;
    else
      v_o <= res_v_i & is_aux;
  end

  // Second cycle of latency
  always_ff @(posedge clk_i)
  begin
    data_o <= result;
  end

endmodule

`default_nettype wire

// File: design/calc_pipe_mul.sv
`timescale 1ns/1ps
`default_nettype none

module calc_pipe_mul
  (input  logic                                     clk_i
  , input logic                                     rst_n_i

  , input logic                                     res_v_i
  , input calc_pkg::calc_op_e                       res_op_i
  , input logic [calc_pkg::calc_data_width_lp-1:0]  res_rs1_i
  , input logic [calc_pkg::calc_data_width_lp-1:0]  res_rs2_i

  , output logic                                    v_o
  , output logic [calc_pkg::calc_data_width_lp-1:0] data_o
  );

  localparam int regs_lp = calc_pkg::calc_mul_stage_lp;

  logic [calc_pkg::calc_data_width_lp-1:0]              product;
  logic [regs_lp-1:0]                                   v_r;
  logic [regs_lp-1:0][calc_pkg::calc_data_width_lp-1:0] data_r;

  // Low half only
  assign product = res_rs1_i * res_rs2_i;

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
      v_r <= '0;
    else
      v_r <= {v_r[regs_lp-2:0], res_v_i & (res_op_i == calc_pkg::e_op_mul)};
  end

  always_ff @(posedge clk_i)
  begin
    data_r <= {data_r[regs_lp-2:0], product};
  end

  assign v_o    = v_r[regs_lp-1];
  assign data_o = data_r[regs_lp-1];

  v_known_a: assert property (@(posedge clk_i) disable iff (!rst_n_i) !$isunknown(v_o));

endmodule

`default_nettype wire

// File: design/calc_completion.sv
`timescale 1ns/1ps
`default_nettype none

module calc_completion
  (input  logic                                          clk_i
  , input logic                                          rst_n_i

  , input logic                                          res_v_i
  , input logic                                          res_kill_i
  , input logic [calc_pkg::calc_reg_addr_width_lp-1:0]   res_rd_addr_i
  , input logic                                          flush_i

  , input logic                                          int_v_i
  , input logic [calc_pkg::calc_data_width_lp-1:0]       int_data_i
  , input logic                                          aux_v_i
  , input logic [calc_pkg::calc_data_width_lp-1:0]       aux_data_i
  , input logic                                          mul_v_i
  , input logic [calc_pkg::calc_data_width_lp-1:0]       mul_data_i

  , output logic [calc_pkg::calc_fwd_els_lp-1:0]         fwd_v_o
  , output logic [calc_pkg::calc_fwd_els_lp-1:0][calc_pkg::calc_reg_addr_width_lp-1:0] fwd_addr_o
  , output logic [calc_pkg::calc_fwd_els_lp-1:0][calc_pkg::calc_data_width_lp-1:0]     fwd_data_o

  , output logic                                         iwb_v_o
  , output logic [calc_pkg::calc_reg_addr_width_lp-1:0]  iwb_rd_addr_o
  , output logic [calc_pkg::calc_data_width_lp-1:0]      iwb_data_o
  );

  localparam int els_lp  = calc_pkg::calc_comp_els_lp;
  localparam int last_lp = calc_pkg::calc_comp_els_lp - 1;

  // Write-valid and result-produced bits per stage
  logic [els_lp-1:0] wv_n, wv_r;
  logic [els_lp-1:0] prod_n, prod_r;

  logic [els_lp-1:0][calc_pkg::calc_reg_addr_width_lp-1:0] addr_n, addr_r;
  logic [els_lp-1:0][calc_pkg::calc_data_width_lp-1:0]     data_n, data_r;

  always_comb
  begin
    wv_n[0]   = res_v_i & ~res_kill_i;
    prod_n[0] = 1'b0;
    addr_n[0] = res_rd_addr_i;
    data_n[0] = '0;
    for (int i = 1; i < els_lp; i++)
    begin
      wv_n[i]   = wv_r[i-1];
      prod_n[i] = prod_r[i-1];
      addr_n[i] = addr_r[i-1];
      data_n[i] = data_r[i-1];
    end

    // Static latencies, so at most one pipe lands per instruction
    prod_n[calc_pkg::calc_int_stage_lp] |= int_v_i;
    data_n[calc_pkg::calc_int_stage_lp] |= int_v_i ? int_data_i : '0;
    prod_n[calc_pkg::calc_aux_stage_lp] |= aux_v_i;
    data_n[calc_pkg::calc_aux_stage_lp] |= aux_v_i ? aux_data_i : '0;
    prod_n[calc_pkg::calc_mul_stage_lp] |= mul_v_i;
    data_n[calc_pkg::calc_mul_stage_lp] |= mul_v_i ? mul_data_i : '0;

    // Flush hits the two youngest
    wv_n[0] &= ~flush_i;
    wv_n[1] &= ~flush_i;
  end

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      wv_r   <= '0;
      prod_r <= '0;
    end
    else
    begin
      wv_r   <= wv_n;
      prod_r <= prod_n;
    end
  end

  always_ff @(posedge clk_i)
  begin
    addr_r <= addr_n;
    data_r <= data_n;
  end

  // Stage inputs youngest first, then the writeback stage
  always_comb
  begin
    for (int i = 0; i < els_lp; i++)
    begin
      fwd_v_o[i]    = wv_n[i] & prod_n[i];
      fwd_addr_o[i] = addr_n[i];
      fwd_data_o[i] = data_n[i];
    end
    fwd_v_o[calc_pkg::calc_fwd_els_lp-1]    = wv_r[last_lp] & prod_r[last_lp];
    fwd_addr_o[calc_pkg::calc_fwd_els_lp-1] = addr_r[last_lp];
    fwd_data_o[calc_pkg::calc_fwd_els_lp-1] = data_r[last_lp];
  end

  assign iwb_v_o       = wv_r[last_lp];
  assign iwb_rd_addr_o = addr_r[last_lp];
  assign iwb_data_o    = data_r[last_lp];

  // An instruction that already has a result must not get a second one
  single_result_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !((aux_v_i && prod_r[calc_pkg::calc_aux_stage_lp-1])
      || (mul_v_i && prod_r[calc_pkg::calc_mul_stage_lp-1])));

endmodule

`default_nettype wire

// File: design/calc_top.sv
`timescale 1ns/1ps
`default_nettype none

module calc_top
  (input  logic                                          clk_i
  , input logic                                          rst_n_i

  , input logic                                          dispatch_v_i
  , input logic                                          poison_i
  , input calc_pkg::calc_op_e                            op_i
  , input logic [calc_pkg::calc_reg_addr_width_lp-1:0]   rd_addr_i
  , input logic [calc_pkg::calc_reg_addr_width_lp-1:0]   rs1_addr_i
  , input logic [calc_pkg::calc_reg_addr_width_lp-1:0]   rs2_addr_i
  , input logic [calc_pkg::calc_data_width_lp-1:0]       rs1_data_i
  , input logic [calc_pkg::calc_data_width_lp-1:0]       rs2_data_i
  , input logic                                          flush_i

  , output logic                                         iwb_v_o
  , output logic [calc_pkg::calc_reg_addr_width_lp-1:0]  iwb_rd_addr_o
  , output logic [calc_pkg::calc_data_width_lp-1:0]      iwb_data_o
  );

  logic                                         res_v, res_kill;
  calc_pkg::calc_op_e                           res_op;
  logic [calc_pkg::calc_reg_addr_width_lp-1:0]  res_rd_addr;
  logic [calc_pkg::calc_data_width_lp-1:0]      res_rs1, res_rs2;

  logic                                         int_v, aux_v, mul_v;
  logic [calc_pkg::calc_data_width_lp-1:0]      int_data, aux_data, mul_data;

  logic [calc_pkg::calc_fwd_els_lp-1:0]                                       fwd_v;
  logic [calc_pkg::calc_fwd_els_lp-1:0][calc_pkg::calc_reg_addr_width_lp-1:0] fwd_addr;
  logic [calc_pkg::calc_fwd_els_lp-1:0][calc_pkg::calc_data_width_lp-1:0]     fwd_data;

  calc_issue issue
    (.clk_i(clk_i)
    ,.rst_n_i(rst_n_i)
    ,.dispatch_v_i(dispatch_v_i)
    ,.poison_i(poison_i)
    ,.op_i(op_i)
    ,.rd_addr_i(rd_addr_i)
    ,.rs1_addr_i(rs1_addr_i)
    ,.rs2_addr_i(rs2_addr_i)
    ,.rs1_data_i(rs1_data_i)
    ,.rs2_data_i(rs2_data_i)
    ,.fwd_v_i(fwd_v)
    ,.fwd_addr_i(fwd_addr)
    ,.fwd_data_i(fwd_data)
    ,.res_v_o(res_v)
    ,.res_kill_o(res_kill)
    ,.res_op_o(res_op)
    ,.res_rd_addr_o(res_rd_addr)
    ,.res_rs1_o(res_rs1)
    ,.res_rs2_o(res_rs2)
    );

  // Integer pipe, result in the reservation cycle
  calc_pipe_int pipe_int
    (.res_v_i(res_v)
    ,.res_op_i(res_op)
    ,.res_rs1_i(res_rs1)
    ,.res_rs2_i(res_rs2)
    ,.v_o(int_v)
    ,.data_o(int_data)
    );

  calc_pipe_aux pipe_aux
    (.clk_i(clk_i)
    ,.rst_n_i(rst_n_i)
    ,.res_v_i(res_v)
    ,.res_op_i(res_op)
    ,.res_rs1_i(res_rs1)
    ,.res_rs2_i(res_rs2)
    ,.v_o(aux_v)
    ,.data_o(aux_data)
    );

  calc_pipe_mul pipe_mul
    (.clk_i(clk_i)
    ,.rst_n_i(rst_n_i)
    ,.res_v_i(res_v)
    ,.res_op_i(res_op)
    ,.res_rs1_i(res_rs1)
    ,.res_rs2_i(res_rs2)
    ,.v_o(mul_v)
    ,.data_o(mul_data)
    );

  calc_completion completion
    (.clk_i(clk_i)
    ,.rst_n_i(rst_n_i)
    ,.res_v_i(res_v)
    ,.res_kill_i(res_kill)
    ,.res_rd_addr_i(res_rd_addr)
    ,.flush_i(flush_i)
    ,.int_v_i(int_v)
    ,.int_data_i(int_data)
    ,.aux_v_i(aux_v)
    ,.aux_data_i(aux_data)
    ,.mul_v_i(mul_v)
    ,.mul_data_i(mul_data)
    ,.fwd_v_o(fwd_v)
    ,.fwd_addr_o(fwd_addr)
    ,.fwd_data_o(fwd_data)
    ,.iwb_v_o(iwb_v_o)
    ,.iwb_rd_addr_o(iwb_rd_addr_o)
    ,.iwb_data_o(iwb_data_o)
    );

endmodule

`default_nettype wire

// File: verif/calc_tb.sv
`timescale 1ns/1ps
`default_nettype none

module calc_tb;

  localparam int test_slots_lp = 400;
  localparam int hist_els_lp   = test_slots_lp + 16;

  logic                                        clk_i;
  logic                                        rst_n_i;
  logic                                        dispatch_v_i;
  logic                                        poison_i;
  calc_pkg::calc_op_e                          op_i;
  logic [calc_pkg::calc_reg_addr_width_lp-1:0] rd_addr_i, rs1_addr_i, rs2_addr_i;
  logic [calc_pkg::calc_data_width_lp-1:0]     rs1_data_i, rs2_data_i;
  logic                                        flush_i;
  logic                                        iwb_v_o;
  logic [calc_pkg::calc_reg_addr_width_lp-1:0] iwb_rd_addr_o;
  logic [calc_pkg::calc_data_width_lp-1:0]     iwb_data_o;

  integer seed;
  int     cyc = 0;
  int     cur_e, slot, n_hist, wb_idx;
  int     mism_cnt, missing_cnt, extra_cnt;
  int     k, rd, rs1, rs2;

  // Committed register state, drives the possibly stale rs data
  logic [31:0] rf_model [32];

  // Every dispatch in program order
  int                 hist_rd   [hist_els_lp];
  int                 hist_cyc  [hist_els_lp];
  logic [31:0]        hist_val  [hist_els_lp];
  logic               hist_kill [hist_els_lp];
  calc_pkg::calc_op_e hist_op   [hist_els_lp];

  // History indices still expected on the writeback port
  int exp_q [$];

  calc_top dut_i
    (.clk_i(clk_i)
    ,.rst_n_i(rst_n_i)
    ,.dispatch_v_i(dispatch_v_i)
    ,.poison_i(poison_i)
    ,.op_i(op_i)
    ,.rd_addr_i(rd_addr_i)
    ,.rs1_addr_i(rs1_addr_i)
    ,.rs2_addr_i(rs2_addr_i)
    ,.rs1_data_i(rs1_data_i)
    ,.rs2_data_i(rs2_data_i)
    ,.flush_i(flush_i)
    ,.iwb_v_o(iwb_v_o)
    ,.iwb_rd_addr_o(iwb_rd_addr_o)
    ,.iwb_data_o(iwb_data_o)
    );

  always #20 clk_i = ~clk_i;

  always @(posedge clk_i)
  begin
    cyc <= cyc + 1;
  end

  function automatic logic [31:0] init_val(input int r);
    return (32'h9e37_79b9 * (r + 1)) ^ (r << 27);
  endfunction

  function automatic logic [31:0] calc_ref
    (input calc_pkg::calc_op_e op, input logic [31:0] a, input logic [31:0] b);
    case (op)
      calc_pkg::e_op_add:  return a + b;
      calc_pkg::e_op_sub:  return a - b;
      calc_pkg::e_op_and:  return a & b;
      calc_pkg::e_op_or:   return a | b;
      calc_pkg::e_op_xor:  return a ^ b;
      calc_pkg::e_op_sll:  return a << b[4:0];
      calc_pkg::e_op_srl:  return a >> b[4:0];
      calc_pkg::e_op_slt:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      calc_pkg::e_op_min:  return ($signed(a) < $signed(b)) ? a : b;
      calc_pkg::e_op_max:  return ($signed(a) >= $signed(b)) ? a : b;
      calc_pkg::e_op_minu: return (a < b) ? a : b;
      calc_pkg::e_op_maxu: return (a >= b) ? a : b;
      calc_pkg::e_op_mul:  return a * b;
      default:             return 32'h0;
    endcase
  endfunction

  function automatic int lat_of(input calc_pkg::calc_op_e op);
    if (op == calc_pkg::e_op_mul)
      return 4;
    if (op inside {calc_pkg::e_op_min, calc_pkg::e_op_max, calc_pkg::e_op_minu, calc_pkg::e_op_maxu})
      return 2;
    return 1;
  endfunction

  // Youngest surviving writer of a register, or -1
  function automatic int find_writer(input int r);
    for (int i = n_hist - 1; i >= 0; i--)
    begin
      if (!hist_kill[i] && (hist_rd[i] == r))
        return i;
    end
    return -1;
  endfunction

  function automatic logic [31:0] read_arch(input int r);
    int idx;
    idx = find_writer(r);
    if (r == 0)
      return 32'h0;
    return (idx < 0) ? init_val(r) : hist_val[idx];
  endfunction

  // Producer far enough back for the bypass network
  function automatic logic src_ok(input int r);
    int idx;
    idx = find_writer(r);
    if ((r == 0) || (idx < 0))
      return 1'b1;
    return (cur_e - hist_cyc[idx]) >= lat_of(hist_op[idx]);
  endfunction

  function automatic int legal_src();
    int r;
    for (int t = 0; t < 4; t++)
    begin
      r = {$random(seed)} % 8;
      if (src_ok(r))
        return r;
    end
    return 0;
  endfunction

  task automatic check_value(input string what, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp)
    begin
      $display("** Error @ %0t: %s is %h, expected %h", $time, what, got, exp);
      mism_cnt++;
    end
  endtask

  // Flush at edge e removes the dispatches of e-1 and e-2
  task automatic kill_recent(input int e);
    for (int i = n_hist - 1; (i >= 0) && (hist_cyc[i] >= e - 2); i--)
      hist_kill[i] = 1'b1;
    while ((exp_q.size() > 0) && (hist_cyc[exp_q[$]] >= e - 2))
      void'(exp_q.pop_back());
  endtask

  task automatic step(input logic flush);
    @(posedge clk_i);
    #1;
    cur_e   = cyc + 1;
    flush_i = flush;
    if (flush)
      kill_recent(cur_e);
    slot++;
  endtask

  task automatic put
    (input logic v, input calc_pkg::calc_op_e op, input int rd_a, input int rs1_a
    , input int rs2_a, input logic poison);
    dispatch_v_i = v;
    poison_i     = poison;
    op_i         = op;
    rd_addr_i    = rd_a[4:0];
    rs1_addr_i   = rs1_a[4:0];
    rs2_addr_i   = rs2_a[4:0];
    rs1_data_i   = rf_model[rs1_a];
    rs2_data_i   = rf_model[rs2_a];
    if (v)
    begin
      hist_rd[n_hist]   = rd_a;
      hist_op[n_hist]   = op;
      hist_cyc[n_hist]  = cur_e;
      hist_kill[n_hist] = poison;
      hist_val[n_hist]  = calc_ref(op, read_arch(rs1_a), read_arch(rs2_a));
      if (!poison)
        exp_q.push_back(n_hist);
      n_hist++;
    end
  endtask

  task automatic issue(input calc_pkg::calc_op_e op, input int rd_a, input int rs1_a, input int rs2_a);
    step(1'b0);
    put(1'b1, op, rd_a, rs1_a, rs2_a, 1'b0);
  endtask

  task automatic idle(input int n);
    repeat (n)
    begin
      step(1'b0);
      put(1'b0, calc_pkg::e_op_add, 0, 0, 0, 1'b0);
    end
  endtask

  // Writeback is due five edges after dispatch, sampled mid-cycle
  always @(negedge clk_i)
  begin
    if (rst_n_i)
    begin
      if ((exp_q.size() > 0) && (hist_cyc[exp_q[0]] + 5 == cyc))
      begin
        wb_idx = exp_q.pop_front();
        if (iwb_v_o !== 1'b1)
        begin
          $display("Missing writeback at %0t for register x%0d", $time, hist_rd[wb_idx]);
          missing_cnt++;
        end
        else
        begin
          check_value("writeback rd", iwb_rd_addr_o, hist_rd[wb_idx]);
          check_value("writeback data", iwb_data_o, hist_val[wb_idx]);
        end
        if (hist_rd[wb_idx] != 0)
          rf_model[hist_rd[wb_idx]] = hist_val[wb_idx];
      end
      else if (iwb_v_o !== 1'b0)
      begin
        $display("Unexpected writeback at %0t to register x%0d", $time, iwb_rd_addr_o);
        extra_cnt++;
      end
    end
  end

  initial
  begin
    #((test_slots_lp + 20) * 40);
    $display("Watchdog timeout, writebacks did not drain in time");
    $display("Simulation failed");
    $finish;
  end

  initial
  begin
    seed         = 32'h39b6_49ca;
    clk_i        = 1'b0;
    rst_n_i      = 1'b0;
    dispatch_v_i = 1'b0;
    poison_i     = 1'b0;
    op_i         = calc_pkg::e_op_add;
    rd_addr_i    = '0;
    rs1_addr_i   = '0;
    rs2_addr_i   = '0;
    rs1_data_i   = '0;
    rs2_data_i   = '0;
    flush_i      = 1'b0;
    for (int i = 0; i < 32; i++)
      rf_model[i] = init_val(i);
    repeat (5) @(posedge clk_i);
    #1 rst_n_i = 1'b1;

    // Quiet port after reset, then one op per class
    idle(3);
    issue(calc_pkg::e_op_add, 3, 1, 2);
    issue(calc_pkg::e_op_xor, 4, 3, 1);
    issue(calc_pkg::e_op_max, 5, 3, 4);
    idle(1);
    issue(calc_pkg::e_op_sub, 6, 5, 3);
    issue(calc_pkg::e_op_mul, 7, 5, 6);
    idle(3);
    issue(calc_pkg::e_op_mul, 8, 7, 7);
    idle(3);
    issue(calc_pkg::e_op_add, 9, 8, 0);

    // x0 written in flight
    issue(calc_pkg::e_op_add, 0, 1, 2);
    issue(calc_pkg::e_op_or, 10, 0, 2);

    // Poisoned producer
    step(1'b0);
    put(1'b1, calc_pkg::e_op_add, 11, 1, 2, 1'b1);
    issue(calc_pkg::e_op_sub, 12, 11, 0);

    // Flush takes out 13 and 14 only
    issue(calc_pkg::e_op_add, 13, 1, 2);
    issue(calc_pkg::e_op_add, 14, 13, 1);
    step(1'b1);
    put(1'b1, calc_pkg::e_op_add, 15, 13, 14, 1'b0);
    issue(calc_pkg::e_op_mul, 16, 1, 2);
    issue(calc_pkg::e_op_mul, 17, 2, 3);
    issue(calc_pkg::e_op_mul, 18, 3, 1);

    while (slot < test_slots_lp)
    begin
      step(({$random(seed)} % 16) == 0);
      k   = {$random(seed)} % 16;
      rd  = {$random(seed)} % 8;
      rs1 = legal_src();
      rs2 = legal_src();
      put(({$random(seed)} % 8) != 0,
          (k > 12) ? calc_pkg::e_op_mul : calc_pkg::calc_op_e'(k[3:0]),
          rd, rs1, rs2, ({$random(seed)} % 12) == 0);
    end

    while (exp_q.size() > 0)
      idle(1);
    idle(3);

    $display("Errors: %0d mismatches, %0d missing writebacks, %0d extra writebacks",
             mism_cnt, missing_cnt, extra_cnt);
    if ((mism_cnt + missing_cnt + extra_cnt) == 0)
      $display("Simulation completed successfully");
    else
      $display("Simulation failed");
    $finish;
  end

endmodule

`default_nettype wire

// File: calc_top.f
design/calc_pkg.sv
design/calc_bypass.sv
design/calc_issue.sv
design/calc_pipe_int.sv
design/calc_pipe_aux.sv
design/calc_pipe_mul.sv
design/calc_completion.sv
design/calc_top.sv
verif/calc_tb.sv
